// File: common/axi_lite_pkg.sv
// AXI-lite response codes and fetch master states; only OKAY and SLVERR are ever produced
package axi_lite_pkg;

    // response codes on rresp and bresp
    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_SLVERR = 2'b10
    } axi_resp_t;

    // read master FSM, one outstanding read at most
    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_BUSY = 1'b1
    } fetch_state_t;

endpackage

// File: common/fetch_settings.svh
// fetch build parameters; addresses are word aligned and the read latency must be at least 1
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// pc after reset
`define FETCH_PC_RST 32'h0000_0000

// log2 of the instruction SRAM depth in 32-bit words
`define FETCH_SRAM_ADDR_BITS 8

// cycles from the accepted read address to rvalid
`define FETCH_SRAM_READ_LATENCY 2

`endif

// File: common/rv_inst_pkg.sv
// RV32 instruction views for predecode; only the I and U layouts are described
package rv_inst_pkg;

    // I-type layout
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_fmt_t;

    // U-type layout
    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_fmt_t;

    // same word seen through both layouts
    // rd and opcode sit at the same bits in each view
    typedef union packed {
        inst_i_fmt_t i;
        inst_u_fmt_t u;
    } rv_inst_u;

    // coarse opcode classes
    typedef enum logic [2:0] {
        OP_ALU_IMM = 3'd0,
        OP_LOAD    = 3'd1,
        OP_JALR    = 3'd2,
        OP_LUI     = 3'd3,
        OP_AUIPC   = 3'd4,
        OP_OTHER   = 3'd5
    } op_class_t;

endpackage

// File: fetch/inst_fetch_unit.sv
// AXI-lite read master, one read in flight; a word is presented only while it matches the current pc
`timescale 1ns/10ps
`include "fetch_settings.svh"

module inst_fetch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_enable,
    input  logic [31:0]             pc,
    input  logic                    arready,
    input  logic                    rvalid,
    input  logic [31:0]             rdata,
    input  axi_lite_pkg::axi_resp_t rresp,
    output logic                    arvalid,
    output logic [31:0]             araddr,
    output logic                    rready,
    output logic [31:0]             inst,
    output logic                    inst_valid,
    output logic                    fetch_error
);

    import axi_lite_pkg::*;

    fetch_state_t state;
    logic [31:0]  last_pc;
    logic         fetched;
    logic         pc_change;
    logic         err_q;
    logic [31:0]  inst_q;
    logic         ar_fire;
    logic         r_fire;

    // a new fetch is needed on a pc change or before the first fetch
    assign pc_change = !fetched || (last_pc != pc);

    assign arvalid = (state == FETCH_IDLE) && fetch_enable && pc_change;
    assign araddr  = pc;
    assign rready  = (state == FETCH_BUSY);

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH_IDLE;
            fetched <= 1'b0;
            last_pc <= `FETCH_PC_RST;
            err_q   <= 1'b0;
        end else begin
            if (ar_fire) begin
                state   <= FETCH_BUSY;
                fetched <= 1'b1;
                last_pc <= pc;
            end else if (r_fire) begin
                state <= FETCH_IDLE;
                err_q <= (rresp != AXI_OKAY);
            end
        end
    end

    // returned word, taken on the R handshake
    always_ff @(posedge clk) begin
        if (r_fire) begin
            inst_q <= rdata;
        end
    end

    // stale words after a redirect fail the pc compare and stay hidden
    assign inst_valid  = (state == FETCH_IDLE) && !pc_change;
    assign inst        = inst_q;
    assign fetch_error = inst_valid && err_q;

endmodule

// File: fetch/pc_sequencer.sv
// program counter; redirect wins over the step by four and nothing moves while fetch_enable is low
`timescale 1ns/10ps
`include "fetch_settings.svh"

module pc_sequencer (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_enable,
    input  logic        inst_valid,
    input  logic        hold,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic [31:0] pc
);

    logic [31:0] pc_q;
    logic [31:0] pc_next;

    // next pc selection
    always_comb begin
        pc_next = pc_q;
        if (fetch_enable) begin
            if (redirect) begin
                pc_next = redirect_pc;
            end else if (inst_valid && !hold) begin
                // advance once the current word has been presented
                pc_next = pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `FETCH_PC_RST;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

endmodule

// File: filelist.f
+incdir+common
common/axi_lite_pkg.sv
common/rv_inst_pkg.sv
fetch/pc_sequencer.sv
fetch/inst_fetch_unit.sv
source/inst_sram.sv
source/inst_predecode.sv
source/fetch_top.sv
sim/fetch_assertions.sv
sim/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs fetch_tb with Verilator from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -f filelist.f -o fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0

// File: sim/fetch_assertions.sv
// concurrent checks on the fetch unit read master; attached to every inst_fetch_unit by bind
`timescale 1ns/10ps

module fetch_assertions (
    input logic        clk,
    input logic        rst,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        rvalid,
    input logic        rready,
    input logic        inst_valid
);

    // request must not vanish or move while the slave stalls
    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr)
    ) else $error("arvalid dropped or araddr changed before arready");

    // a word is presented only the cycle after its read completes
    a_valid_after_read: assert property (
        @(posedge clk) disable iff (rst)
        $rose(inst_valid) |-> $past(rvalid && rready)
    ) else $error("inst_valid rose without a read completing the cycle before");

    // outputs left behind by each reset edge
    a_quiet_in_reset: assert property (
        @(posedge clk)
        rst |=> !arvalid && !inst_valid
    ) else $error("arvalid or inst_valid high after a reset edge");

endmodule

bind inst_fetch_unit fetch_assertions u_fetch_assertions (
    .clk        (clk),
    .rst        (rst),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .inst_valid (inst_valid)
);

// File: sim/fetch_tb.sv
// run from the project root so sim/fetch_testdata.txt resolves; program is loaded before fetch_enable
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_tb;

    import axi_lite_pkg::*;
    import rv_inst_pkg::*;

    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst;
    logic        fetch_enable;
    logic        hold;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        awvalid;
    logic [31:0] awaddr;
    logic        awready;
    logic        wvalid;
    logic [31:0] wdata;
    logic        wready;
    logic        bvalid;
    axi_resp_t   bresp;
    logic        bready;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        inst_valid;
    logic        fetch_error;
    op_class_t   op_class;
    logic [4:0]  rd;
    logic [31:0] imm;

    logic [31:0] stim [0:255];
    logic [7:0]  rd_ptr;
    logic [31:0] rnd_state;
    string       test_name;

    fetch_top uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // xorshift32
    function automatic logic [31:0] next_random();
        rnd_state = rnd_state ^ (rnd_state << 13);
        rnd_state = rnd_state ^ (rnd_state >> 17);
        rnd_state = rnd_state ^ (rnd_state << 5);
        return rnd_state;
    endfunction

    function automatic void compare_word(input string field, input logic [31:0] expected,
                                         input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s expected %08h actual %08h", test_name, field, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", field);
        end
    endfunction

    function automatic void confirm(input logic ok, input string msg);
        assert (ok) else begin
            $display("%s during %s", msg, test_name);
            $display("TEST FAILED");
            $fatal(1, "%s", msg);
        end
    endfunction

    function automatic logic [31:0] next_word();
        logic [31:0] w;
        confirm(rd_ptr != 8'hff, "test data has no end record");
        w = stim[rd_ptr];
        rd_ptr = rd_ptr + 8'd1;
        return w;
    endfunction

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic [31:0] exp_resp);
        int cycles;
        test_name = $sformatf("load %08h", addr);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!awready && cycles < TIMEOUT);
        confirm(awready && wready, "write address and data were never accepted");
        // word is written at this edge
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!bvalid && cycles < TIMEOUT);
        confirm(bvalid, "bvalid never rose");
        compare_word("bresp", exp_resp, 32'(bresp));
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic issue_redirect(input logic [31:0] target);
        test_name = $sformatf("redirect %08h", target);
        // pc steps past the presented word, then its successor's address is accepted
        @(posedge clk);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(negedge clk);
        confirm(uut.rready === 1'b1, "redirect did not meet a read in flight");
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    task automatic expect_fetch(input logic [31:0] exp_pc, exp_inst, exp_class, exp_rd,
                                exp_imm, exp_err);
        int cycles;
        int n_hold;
        test_name = $sformatf("fetch %08h", exp_pc);
        n_hold = int'(next_random() % 32'd4);
        // hold only matters once the word is presented
        @(posedge clk);
        hold <= (n_hold != 0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!inst_valid && cycles < TIMEOUT);
        confirm(inst_valid, "inst_valid never rose");
        compare_word("pc", exp_pc, pc);
        compare_word("inst", exp_inst, inst);
        compare_word("op_class", exp_class, 32'(op_class));
        compare_word("rd", exp_rd, 32'(rd));
        compare_word("imm", exp_imm, imm);
        compare_word("fetch_error", exp_err, 32'(fetch_error));
        for (int k = 0; k < n_hold; k++) begin
            @(posedge clk);
            if (k == n_hold - 1) begin
                hold <= 1'b0;
            end
            @(negedge clk);
            compare_word("held inst_valid", 32'd1, 32'(inst_valid));
            compare_word("held pc", exp_pc, pc);
            compare_word("held inst", exp_inst, inst);
            compare_word("held op_class", exp_class, 32'(op_class));
            compare_word("held rd", exp_rd, 32'(rd));
            compare_word("held imm", exp_imm, imm);
        end
    endtask

    initial begin
        logic [31:0] kind;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [31:0] w4;
        logic [31:0] w5;
        rst          <= 1'b1;
        fetch_enable <= 1'b0;
        hold         <= 1'b0;
        redirect     <= 1'b0;
        redirect_pc  <= 32'd0;
        awvalid      <= 1'b0;
        awaddr       <= 32'd0;
        wvalid       <= 1'b0;
        wdata        <= 32'd0;
        bready       <= 1'b0;
        rnd_state = 32'hee2e;
        rd_ptr = 8'd0;
        test_name = "reset";
        $readmemh("sim/fetch_testdata.txt", stim);

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_word("pc", `FETCH_PC_RST, pc);
        compare_word("inst_valid", 32'd0, 32'(inst_valid));
        compare_word("fetch_error", 32'd0, 32'(fetch_error));
        compare_word("bvalid", 32'd0, 32'(bvalid));
        compare_word("arvalid", 32'd0, 32'(uut.arvalid));
        compare_word("rvalid", 32'd0, 32'(uut.rvalid));

        kind = next_word();
        while (kind != 32'd0) begin
            case (kind)
                32'd1: begin
                    w0 = next_word();
                    w1 = next_word();
                    w2 = next_word();
                    load_word(w0, w1, w2);
                end
                32'd2: begin
                    @(posedge clk);
                    fetch_enable <= 1'b1;
                end
                32'd3: begin
                    w0 = next_word();
                    w1 = next_word();
                    w2 = next_word();
                    w3 = next_word();
                    w4 = next_word();
                    w5 = next_word();
                    expect_fetch(w0, w1, w2, w3, w4, w5);
                end
                32'd4: begin
                    w0 = next_word();
                    issue_redirect(w0);
                end
                default: begin
                    confirm(1'b0, "unknown record kind in the test data");
                end
            endcase
            kind = next_word();
        end

        @(posedge clk);
        fetch_enable <= 1'b0;
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sim/fetch_testdata.txt
// load: 1 addr word bresp | enable: 2 | redirect: 4 target_pc | end: 0
// expect: 3 pc inst op_class rd imm fetch_error
1 00000000 00500093 0
1 00000004 ffc0a103 0
1 00000008 123451b7 0
1 0000000c abcde217 0
1 00000010 7ff302e7 0
1 00000014 002083b3 0
1 00000018 fff40413 0
1 00000100 80000537 0
1 00000104 12350593 0
// first word past the 256-word array
1 00000400 deadbeef 2
2
3 00000000 00500093 0 01 00000005 0
3 00000004 ffc0a103 1 02 fffffffc 0
3 00000008 123451b7 3 03 12345000 0
3 0000000c abcde217 4 04 abcde000 0
3 00000010 7ff302e7 2 05 000007ff 0
3 00000014 002083b3 5 07 00000000 0
// word at 0x18 is in flight when this redirect lands
4 00000100
3 00000100 80000537 3 0a 80000000 0
3 00000104 12350593 0 0b 00000123 0
4 00001000
3 00001000 00000000 5 00 00000000 1
0

// File: source/fetch_top.sv
// fetch front end; the write channel is for program loading before fetch_enable is raised
`timescale 1ns/10ps

module fetch_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_enable,
    input  logic                    hold,
    input  logic                    redirect,
    input  logic [31:0]             redirect_pc,
    input  logic                    awvalid,
    input  logic [31:0]             awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  logic [31:0]             wdata,
    output logic                    wready,
    output logic                    bvalid,
    output axi_lite_pkg::axi_resp_t bresp,
    input  logic                    bready,
    output logic [31:0]             pc,
    output logic [31:0]             inst,
    output logic                    inst_valid,
    output logic                    fetch_error,
    output rv_inst_pkg::op_class_t  op_class,
    output logic [4:0]              rd,
    output logic [31:0]             imm
);

    import axi_lite_pkg::*;

    // read channel between fetch unit and SRAM
    logic        arvalid;
    logic [31:0] araddr;
    logic        arready;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    axi_resp_t   rresp;

    pc_sequencer u_pc_sequencer (
        .clk          (clk),
        .rst          (rst),
        .fetch_enable (fetch_enable),
        .inst_valid   (inst_valid),
        .hold         (hold),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .pc           (pc)
    );

    inst_fetch_unit u_inst_fetch_unit (
        .clk          (clk),
        .rst          (rst),
        .fetch_enable (fetch_enable),
        .pc           (pc),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .arvalid      (arvalid),
        .araddr       (araddr),
        .rready       (rready),
        .inst         (inst),
        .inst_valid   (inst_valid),
        .fetch_error  (fetch_error)
    );

    inst_sram u_inst_sram (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .araddr  (araddr),
        .rready  (rready),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .bready  (bready),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp)
    );

    inst_predecode u_inst_predecode (
        .inst     (inst),
        .op_class (op_class),
        .rd       (rd),
        .imm      (imm)
    );

endmodule

// File: source/inst_predecode.sv
// predecode of opcode class, rd and immediate only; no validity check of funct fields
`timescale 1ns/10ps

module inst_predecode (
    input  logic [31:0]             inst,
    output rv_inst_pkg::op_class_t  op_class,
    output logic [4:0]              rd,
    output logic [31:0]             imm
);

    import rv_inst_pkg::*;

    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;

    rv_inst_u word;

    assign word = inst;
    assign rd   = word.i.rd;

    // opcode is read through the I view, same bits as the U view
    always_comb begin
        case (word.i.opcode)
            OPC_ALU_IMM: op_class = OP_ALU_IMM;
            OPC_LOAD:    op_class = OP_LOAD;
            OPC_JALR:    op_class = OP_JALR;
            OPC_LUI:     op_class = OP_LUI;
            OPC_AUIPC:   op_class = OP_AUIPC;
            default:     op_class = OP_OTHER;
        endcase
    end

    always_comb begin
        case (op_class)
            OP_ALU_IMM, OP_LOAD, OP_JALR: begin
                // sign extend the 12-bit field
                imm = {{20{word.i.imm_11_0[11]}}, word.i.imm_11_0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {word.u.imm_31_12, 12'd0};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

// File: source/inst_sram.sv
// AXI-lite instruction memory, one read and one write response outstanding; out-of-range words give SLVERR
`timescale 1ns/10ps
`include "fetch_settings.svh"

module inst_sram (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    arvalid,
    input  logic [31:0]             araddr,
    input  logic                    rready,
    output logic                    arready,
    output logic                    rvalid,
    output logic [31:0]             rdata,
    output axi_lite_pkg::axi_resp_t rresp,
    input  logic                    awvalid,
    input  logic [31:0]             awaddr,
    input  logic                    wvalid,
    input  logic [31:0]             wdata,
    input  logic                    bready,
    output logic                    awready,
    output logic                    wready,
    output logic                    bvalid,
    output axi_lite_pkg::axi_resp_t bresp
);

    import axi_lite_pkg::*;

    localparam int ADDR_BITS = `FETCH_SRAM_ADDR_BITS;
    localparam int DEPTH     = 1 << ADDR_BITS;
    localparam int LATENCY   = `FETCH_SRAM_READ_LATENCY;
    localparam int CNT_W     = $clog2(LATENCY + 1);

    logic [31:0]      mem [0:DEPTH-1];
    logic             rd_busy;
    logic [CNT_W-1:0] rd_cnt;
    logic             rd_in_range;
    logic             wr_in_range;
    logic             wr_fire;

    // word index sits above the byte offset, anything higher is out of range
    assign rd_in_range = (araddr[31:ADDR_BITS+2] == '0);
    assign wr_in_range = (awaddr[31:ADDR_BITS+2] == '0);

    assign arready = !rd_busy;

    // address and data are accepted together
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign wr_fire = awready;

    // read latency counter
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
            rd_cnt  <= '0;
        end else if (arvalid && arready) begin
            rd_busy <= 1'b1;
            rvalid  <= (LATENCY == 1);
            rd_cnt  <= CNT_W'(LATENCY - 1);
        end else if (rvalid) begin
            if (rready) begin
                rd_busy <= 1'b0;
                rvalid  <= 1'b0;
            end
        end else if (rd_busy) begin
            if (rd_cnt == CNT_W'(1)) begin
                rvalid <= 1'b1;
            end
            rd_cnt <= rd_cnt - CNT_W'(1);
        end
    end

    // read payload captured at the address handshake
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= rd_in_range ? mem[araddr[ADDR_BITS+1:2]] : 32'd0;
            rresp <= rd_in_range ? AXI_OKAY : AXI_SLVERR;
        end
    end

    // write response
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= AXI_OKAY;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            bresp  <= wr_in_range ? AXI_OKAY : AXI_SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && wr_in_range) begin
            mem[awaddr[ADDR_BITS+1:2]] <= wdata;
        end
    end

endmodule
